//--- Makefile
TOP  := tb_ofdm_payload
SRCS := $(shell grep -v '^+' sources.f)

.PHONY: all run clean

all: obj_dir/V$(TOP)

obj_dir/V$(TOP): sources.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f

run: obj_dir/V$(TOP)
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '=== PASS ==='

clean:
	rm -rf obj_dir

//--- common/group_if.sv
`timescale 1ns/1ns
`default_nettype none

// one mapped group, collector to lanes and framer
interface group_if;

    logic                                              grp_stb;
    ofdm_pkg::mod_e                                    grp_mod;
    // group number within the symbol, 0 to 23
    logic [4:0]                                        grp_idx;
    logic [ofdm_pkg::LANES-1:0][ofdm_pkg::CHUNK_W-1:0] grp_bits;

    modport src  (output grp_stb, output grp_mod, output grp_idx, output grp_bits);
    modport lane (input grp_mod, input grp_bits);
    modport sink (input grp_stb, input grp_idx);

endinterface

`default_nettype wire

//--- common/ofdm_pkg.sv
`default_nettype none

package ofdm_pkg;

    // modulation codes, code 3 is not used
    typedef enum logic [1:0]
    {
        MOD_BPSK  = 2'd0,
        MOD_QPSK  = 2'd1,
        MOD_QAM16 = 2'd2
    } mod_e;

    // points per group and bits per lane chunk
    localparam int LANES   = 8;
    localparam int CHUNK_W = 4;

    // symbol layout for the 256-point IFFT
    localparam int N_DATA   = 192;
    localparam int N_GROUPS = 24;
    localparam int N_BINS   = 256;
    localparam int BIN_W    = 8;

    localparam logic [BIN_W-1:0] GUARD_LO = 8'd101;
    localparam logic [BIN_W-1:0] GUARD_HI = 8'd155;

    // pilot k sits in slot k, lowest bin first
    localparam logic [LANES-1:0][BIN_W-1:0] PILOT_BINS =
        {8'd243, 8'd218, 8'd193, 8'd168, 8'd88, 8'd63, 8'd38, 8'd13};
    // pilots at 38, 88, 193 and 243 carry -A on i
    localparam logic [LANES-1:0] PILOT_NEG = 8'b1010_1010;

    localparam int MAP_AMP = 1024;

    function automatic int bytes_per_group(mod_e mod);
        case (mod)
            MOD_BPSK:  return 1;
            MOD_QPSK:  return 2;
            default:   return 4;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- framer/subcarrier_framer.sv
`timescale 1ns/1ns
`default_nettype none

module subcarrier_framer
#(
    parameter int DATA_W = 16
)
(
    input  logic                             clk,
    input  logic                             reset,
    group_if.sink                            grp,
    input  logic signed [DATA_W-1:0]         pts_i [ofdm_pkg::LANES],
    input  logic signed [DATA_W-1:0]         pts_q [ofdm_pkg::LANES],
    output logic                             busy_o,
    output logic                             out_valid_o,
    output logic [ofdm_pkg::BIN_W-1:0]       bin_index_o,
    output logic signed [DATA_W-1:0]         out_i_o,
    output logic signed [DATA_W-1:0]         out_q_o,
    output logic                             sym_done_o
);

    localparam logic signed [DATA_W-1:0] AMP = DATA_W'(ofdm_pkg::MAP_AMP);

    logic signed [DATA_W-1:0] store_i [ofdm_pkg::N_DATA];
    logic signed [DATA_W-1:0] store_q [ofdm_pkg::N_DATA];

    logic                        busy;
    logic [ofdm_pkg::BIN_W-1:0]  bin_cnt;
    logic [7:0]                  data_idx;
    logic                        sym_start;
    logic                        is_zero;
    logic                        is_pilot;
    logic                        pilot_neg;
    logic                        is_data;

    // last group of the symbol has arrived
    assign sym_start = grp.grp_stb && (grp.grp_idx == 5'(ofdm_pkg::N_GROUPS - 1));

    ////////////////////////////////////////////////////////////////////////////
    // data point store
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (grp.grp_stb)
        begin
            for (int l = 0; l < ofdm_pkg::LANES; l++)
            begin
                store_i[{grp.grp_idx, 3'(l)}] <= pts_i[l];
                store_q[{grp.grp_idx, 3'(l)}] <= pts_q[l];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // bin classification
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        is_pilot  = 1'b0;
        pilot_neg = 1'b0;
        for (int p = 0; p < ofdm_pkg::LANES; p++)
        begin
            if (bin_cnt == ofdm_pkg::PILOT_BINS[p])
            begin
                is_pilot  = 1'b1;
                pilot_neg = ofdm_pkg::PILOT_NEG[p];
            end
        end
    end

    // DC bin and the guard band stay empty
    assign is_zero = (bin_cnt == '0) ||
                     ((bin_cnt >= ofdm_pkg::GUARD_LO) && (bin_cnt <= ofdm_pkg::GUARD_HI));
    assign is_data = busy && !is_zero && !is_pilot;

    ////////////////////////////////////////////////////////////////////////////
    // bin sequencing
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy     <= 1'b0;
            bin_cnt  <= '0;
            data_idx <= '0;
        end
        else if (sym_start)
        begin
            busy     <= 1'b1;
            bin_cnt  <= '0;
            data_idx <= '0;
        end
        else if (busy)
        begin
            bin_cnt <= bin_cnt + 1'b1;
            // read pointer only moves on data bins
            if (is_data)
            begin
                data_idx <= data_idx + 8'd1;
            end
            if (bin_cnt == '1)
            begin
                busy <= 1'b0;
            end
        end
    end

    always_comb
    begin
        out_i_o = '0;
        out_q_o = '0;
        if (is_pilot)
        begin
            out_i_o = pilot_neg ? -AMP : AMP;
        end
        else if (is_data)
        begin
            out_i_o = store_i[data_idx];
            out_q_o = store_q[data_idx];
        end
    end

    assign busy_o      = busy;
    assign out_valid_o = busy;
    assign bin_index_o = bin_cnt;
    assign sym_done_o  = busy && (bin_cnt == '1);

endmodule

`default_nettype wire

//--- sources.f
common/ofdm_pkg.sv
common/group_if.sv
verilog/byte_collector.sv
verilog/constellation_mapper.sv
framer/subcarrier_framer.sv
verilog/ofdm_payload_top.sv
test/ofdm_payload_assertions.sv
test/tb_ofdm_payload.sv

//--- test/ofdm_payload_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module ofdm_payload_assertions
(
    input logic                       clk,
    input logic                       reset,
    input logic                       ready_o,
    input logic                       out_valid_o,
    input logic [ofdm_pkg::BIN_W-1:0] bin_index_o,
    input logic                       sym_done_o
);

    localparam int BW = ofdm_pkg::BIN_W;

    // input side stays closed while bins stream
    valid_while_ready: assert property (@(posedge clk) disable iff (reset)
        out_valid_o |-> !ready_o)
        else $error("out_valid_o high while ready_o high");

    done_on_last_bin: assert property (@(posedge clk) disable iff (reset)
        sym_done_o |-> (out_valid_o && (bin_index_o == BW'(255))))
        else $error("sym_done_o outside the last valid bin");

    // no gaps or skips inside a symbol
    bin_step: assert property (@(posedge clk) disable iff (reset)
        (out_valid_o && $past(out_valid_o)) |->
        (bin_index_o == BW'($past(bin_index_o) + 1)))
        else $error("bin_index_o did not advance by one");

endmodule

bind ofdm_payload_top ofdm_payload_assertions u_assertions
(
    .clk         (clk),
    .reset       (reset),
    .ready_o     (ready_o),
    .out_valid_o (out_valid_o),
    .bin_index_o (bin_index_o),
    .sym_done_o  (sym_done_o)
);

`default_nettype wire

//--- test/tb_ofdm_payload.sv
`timescale 1ns/1ns
`default_nettype none

module tb_ofdm_payload;

    localparam int DATA_W  = 16;
    localparam int AMP     = 1024;
    localparam int TIMEOUT = 2000;

    logic                     clk;
    logic                     reset;
    logic                     data_valid_i;
    logic [7:0]               data_i;
    logic [1:0]               mod_i;
    logic                     ready_o;
    logic                     out_valid_o;
    logic [7:0]               bin_index_o;
    logic signed [DATA_W-1:0] out_i_o;
    logic signed [DATA_W-1:0] out_q_o;
    logic                     sym_done_o;

    int seed            = 84;
    int cycle           = 0;
    int errors          = 0;
    int checks          = 0;
    int timeouts        = 0;
    int symbols_done    = 0;
    int last_byte_cycle = 0;

    // accepted bytes, one word per group of the symbol
    logic [31:0] grp_word [24];
    int          grp_mod  [24];
    int          byte_pos;
    int          grp_pos;
    int          closed_cycles;

    int              exp_bin;
    int              bins_seen;
    logic            prev_valid;
    logic [2*DATA_W-1:0] exp_pt;

    ofdm_payload_top #(.DATA_W(DATA_W)) dut_i
    (
        .clk          (clk),
        .reset        (reset),
        .data_valid_i (data_valid_i),
        .data_i       (data_i),
        .mod_i        (mod_i),
        .ready_o      (ready_o),
        .out_valid_o  (out_valid_o),
        .bin_index_o  (bin_index_o),
        .out_i_o      (out_i_o),
        .out_q_o      (out_q_o),
        .sym_done_o   (sym_done_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
    end

    function automatic int group_size(int mod);
        if (mod == 0)
            return 1;
        if (mod == 1)
            return 2;
        return 4;
    endfunction

    // gray axis 00 -3A, 01 -A, 11 +A, 10 +3A
    function automatic int axis_level(logic [1:0] b);
        case (b)
            2'b00:   return -3 * AMP;
            2'b01:   return -AMP;
            2'b11:   return AMP;
            default: return 3 * AMP;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // expected i/q of one bin, packed as {i, q}
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [2*DATA_W-1:0] ref_bin(int bin);
        int pilots [8] = '{13, 38, 63, 88, 168, 193, 218, 243};
        int d;
        int g;
        int l;
        int i_val;
        int q_val;
        d = bin - 1;
        i_val = 0;
        q_val = 0;
        if (bin == 0 || (bin >= 101 && bin <= 155))
            return '0;
        for (int p = 0; p < 8; p++)
        begin
            // odd pilots carry -A
            if (bin == pilots[p])
                return {DATA_W'((p % 2 == 1) ? -AMP : AMP), DATA_W'(0)};
            if (bin > pilots[p])
                d--;
        end
        if (bin > 155)
            d -= 55;
        g = d / 8;
        l = d % 8;
        case (grp_mod[g])
            0:
            begin
                i_val = grp_word[g][l] ? AMP : -AMP;
            end
            1:
            begin
                i_val = grp_word[g][2*l] ? AMP : -AMP;
                q_val = grp_word[g][2*l+1] ? AMP : -AMP;
            end
            default:
            begin
                i_val = axis_level(grp_word[g][4*l +: 2]);
                q_val = axis_level(grp_word[g][4*l+2 +: 2]);
            end
        endcase
        return {DATA_W'(i_val), DATA_W'(q_val)};
    endfunction

    task automatic check_value(string name, int got, int exp);
        checks++;
        if (got != exp)
        begin
            errors++;
            $display("ERROR t=%0t %s: got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // record bytes the handshake accepts
    always @(posedge clk)
    begin
        if (reset)
        begin
            byte_pos      = 0;
            grp_pos       = 0;
            closed_cycles = 0;
        end
        else
        begin
            // input stays closed for the group strobe cycle and all 256 bins
            check_value("ready_o", int'(ready_o), int'(closed_cycles == 0));
            if (closed_cycles > 0)
                closed_cycles--;
            if (data_valid_i && ready_o && mod_i != 2'd3)
            begin
                if (byte_pos == 0)
                begin
                    grp_mod[grp_pos]  = int'(mod_i);
                    grp_word[grp_pos] = 32'd0;
                end
                grp_word[grp_pos][8*byte_pos +: 8] = data_i;
                byte_pos++;
                if (byte_pos == group_size(grp_mod[grp_pos]))
                begin
                    byte_pos = 0;
                    grp_pos++;
                    if (grp_pos == 24)
                    begin
                        grp_pos         = 0;
                        last_byte_cycle = cycle;
                        closed_cycles   = 257;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // output compare
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        if (reset)
        begin
            exp_bin    = 0;
            bins_seen  = 0;
            prev_valid = 1'b0;
        end
        else if (out_valid_o)
        begin
            if (!prev_valid)
                check_value("first_valid_delay", cycle - last_byte_cycle, 2);
            exp_pt = ref_bin(exp_bin);
            check_value("bin_index_o", int'(bin_index_o), exp_bin);
            check_value("out_i_o", int'(out_i_o), int'($signed(exp_pt[2*DATA_W-1:DATA_W])));
            check_value("out_q_o", int'(out_q_o), int'($signed(exp_pt[DATA_W-1:0])));
            check_value("sym_done_o", int'(sym_done_o), int'(exp_bin == 255));
            exp_bin++;
            bins_seen++;
            if (sym_done_o)
            begin
                check_value("bin_count", bins_seen, 256);
                exp_bin   = 0;
                bins_seen = 0;
                symbols_done++;
            end
            prev_valid = 1'b1;
        end
        else
        begin
            prev_valid = 1'b0;
        end
    end

    task automatic send_byte(logic [7:0] b, logic [1:0] m);
        int waited;
        waited = 0;
        data_valid_i <= 1'b1;
        data_i       <= b;
        mod_i        <= m;
        @(posedge clk);
        while (!ready_o && waited < TIMEOUT)
        begin
            @(posedge clk);
            waited++;
        end
        if (waited >= TIMEOUT)
        begin
            timeouts++;
            $display("timeout: ready_o stayed low while a byte was offered");
        end
    endtask

    // code 3 for one cycle
    task automatic offer_invalid();
        data_valid_i <= 1'b1;
        data_i       <= 8'($random(seed));
        mod_i        <= 2'd3;
        @(posedge clk);
    endtask

    // kind 3 picks a modulation per group and random codes on later bytes
    task automatic send_symbol(int kind, bit junk);
        int m;
        int bm;
        for (int g = 0; g < 24; g++)
        begin
            m = (kind == 3) ? int'($unsigned($random(seed)) % 3) : kind;
            for (int k = 0; k < group_size(m); k++)
            begin
                bm = (k == 0 || kind != 3) ? m : int'($unsigned($random(seed)) % 3);
                if (junk && ($unsigned($random(seed)) % 4 == 0))
                    offer_invalid();
                send_byte(8'($random(seed)), 2'(bm));
            end
        end
        data_valid_i <= 1'b0;
    endtask

    // bytes offered while the DUT is streaming
    task automatic flood_while_busy(int n);
        for (int k = 0; k < n; k++)
        begin
            data_valid_i <= 1'b1;
            data_i       <= 8'($random(seed));
            mod_i        <= 2'($unsigned($random(seed)) % 3);
            @(posedge clk);
        end
        data_valid_i <= 1'b0;
    endtask

    task automatic wait_symbols(int target);
        int waited;
        waited = 0;
        while (symbols_done < target && waited < TIMEOUT)
        begin
            @(posedge clk);
            waited++;
        end
        if (symbols_done < target)
        begin
            timeouts++;
            $display("timeout: sym_done_o did not arrive for symbol %0d", target);
        end
    endtask

    task automatic report_test(int num, string name, int base);
        int bad;
        bad = errors + timeouts - base;
        if (bad == 0)
            $display("test %0d %s: ok", num, name);
        else
            $display("test %0d %s: %0d problems", num, name, bad);
    endtask

    initial
    begin
        int base;
        reset        = 1'b1;
        data_valid_i = 1'b0;
        data_i       = 8'd0;
        mod_i        = 2'd0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        base = errors + timeouts;
        send_symbol(0, 1'b0);
        wait_symbols(1);
        report_test(1, "bpsk symbol", base);

        base = errors + timeouts;
        send_symbol(1, 1'b0);
        send_symbol(2, 1'b0);
        wait_symbols(3);
        report_test(2, "qpsk and qam16 symbols", base);

        base = errors + timeouts;
        send_symbol(3, 1'b0);
        wait_symbols(4);
        report_test(3, "mixed modulation symbol", base);

        base = errors + timeouts;
        send_symbol(2, 1'b0);
        wait_symbols(5);
        report_test(4, "pilots and sym_done", base);

        base = errors + timeouts;
        send_symbol(3, 1'b1);
        flood_while_busy(20);
        send_symbol(0, 1'b0);
        wait_symbols(7);
        report_test(5, "ignored bytes", base);

        base = errors + timeouts;
        send_symbol(1, 1'b0);
        send_symbol(3, 1'b0);
        wait_symbols(9);
        report_test(6, "back to back symbols", base);

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/byte_collector.sv
`timescale 1ns/1ns
`default_nettype none

module byte_collector
(
    input  logic       clk,
    input  logic       reset,
    input  logic       data_valid_i,
    input  logic [7:0] data_i,
    input  logic [1:0] mod_i,
    input  logic       busy_i,
    output logic       ready_o,
    group_if.src       grp
);

    logic [31:0]    word_q;
    logic [31:0]    word_next;
    logic [31:0]    word_al;
    logic [1:0]     byte_cnt;
    logic [4:0]     grp_cnt;
    ofdm_pkg::mod_e mod_q;
    ofdm_pkg::mod_e cur_mod;
    logic           accept;
    logic           grp_last;
    logic           full;

    logic [ofdm_pkg::LANES-1:0][ofdm_pkg::CHUNK_W-1:0] chunks;

    // symbol complete or framer still streaming
    assign ready_o   = !(full || busy_i);
    assign accept    = data_valid_i && ready_o && (mod_i != 2'd3);
    // first byte of a group sets the modulation
    assign cur_mod   = (byte_cnt == 2'd0) ? ofdm_pkg::mod_e'(mod_i) : mod_q;
    assign word_next = {data_i, word_q[31:8]};
    assign grp_last  = (byte_cnt == 2'(ofdm_pkg::bytes_per_group(cur_mod) - 1));

    ////////////////////////////////////////////////////////////////////////////
    // group word alignment and lane chunks
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        // short groups end up in the top bytes after shifting
        case (cur_mod)
            ofdm_pkg::MOD_BPSK: word_al = {24'd0, word_next[31:24]};
            ofdm_pkg::MOD_QPSK: word_al = {16'd0, word_next[31:16]};
            default:            word_al = word_next;
        endcase

        for (int l = 0; l < ofdm_pkg::LANES; l++)
        begin
            case (cur_mod)
                ofdm_pkg::MOD_BPSK: chunks[l] = {3'b000, word_al[l]};
                ofdm_pkg::MOD_QPSK: chunks[l] = {2'b00, word_al[2*l +: 2]};
                default:            chunks[l] = word_al[4*l +: 4];
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            word_q <= word_next;
            if (byte_cnt == 2'd0)
            begin
                mod_q <= cur_mod;
            end
        end
        if (accept && grp_last)
        begin
            grp.grp_mod  <= cur_mod;
            grp.grp_idx  <= grp_cnt;
            grp.grp_bits <= chunks;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // byte and group counting
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            byte_cnt    <= '0;
            grp_cnt     <= '0;
            full        <= 1'b0;
            grp.grp_stb <= 1'b0;
        end
        else
        begin
            grp.grp_stb <= accept && grp_last;
            // framer has taken over holding off input
            if (busy_i)
            begin
                full <= 1'b0;
            end
            if (accept)
            begin
                if (grp_last)
                begin
                    byte_cnt <= '0;
                    if (grp_cnt == 5'(ofdm_pkg::N_GROUPS - 1))
                    begin
                        grp_cnt <= '0;
                        full    <= 1'b1;
                    end
                    else
                    begin
                        grp_cnt <= grp_cnt + 5'd1;
                    end
                end
                else
                begin
                    byte_cnt <= byte_cnt + 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/constellation_mapper.sv
`timescale 1ns/1ns
`default_nettype none

module constellation_mapper
#(
    parameter int DATA_W = 16,
    parameter int LANE   = 0
)
(
    group_if.lane                    lane,
    output logic signed [DATA_W-1:0] pt_i_o,
    output logic signed [DATA_W-1:0] pt_q_o
);

    localparam logic signed [DATA_W-1:0] AMP   = DATA_W'(ofdm_pkg::MAP_AMP);
    localparam logic signed [DATA_W-1:0] AMP_3 = DATA_W'(3 * ofdm_pkg::MAP_AMP);

    logic [ofdm_pkg::CHUNK_W-1:0] chunk;

    // gray coded 4-level axis
    function automatic logic signed [DATA_W-1:0] gray_level(input logic [1:0] b);
        case (b)
            2'b00:   return -AMP_3;
            2'b01:   return -AMP;
            2'b11:   return AMP;
            default: return AMP_3;
        endcase
    endfunction

    assign chunk = lane.grp_bits[LANE];

    always_comb
    begin
        pt_i_o = '0;
        pt_q_o = '0;
        case (lane.grp_mod)
            ofdm_pkg::MOD_BPSK:
            begin
                pt_i_o = chunk[0] ? AMP : -AMP;
            end
            ofdm_pkg::MOD_QPSK:
            begin
                pt_i_o = chunk[0] ? AMP : -AMP;
                pt_q_o = chunk[1] ? AMP : -AMP;
            end
            ofdm_pkg::MOD_QAM16:
            begin
                pt_i_o = gray_level(chunk[1:0]);
                pt_q_o = gray_level(chunk[3:2]);
            end
            default:
            begin
                pt_i_o = '0;
                pt_q_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/ofdm_payload_top.sv
`timescale 1ns/1ns
`default_nettype none

module ofdm_payload_top
#(
    parameter int DATA_W = 16
)
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       data_valid_i,
    input  logic [7:0]                 data_i,
    input  logic [1:0]                 mod_i,
    output logic                       ready_o,
    output logic                       out_valid_o,
    output logic [ofdm_pkg::BIN_W-1:0] bin_index_o,
    output logic signed [DATA_W-1:0]   out_i_o,
    output logic signed [DATA_W-1:0]   out_q_o,
    output logic                       sym_done_o
);

    group_if grp ();

    logic signed [DATA_W-1:0] pt_i [ofdm_pkg::LANES];
    logic signed [DATA_W-1:0] pt_q [ofdm_pkg::LANES];
    logic                     busy;

    byte_collector u_collector
    (
        .clk          (clk),
        .reset        (reset),
        .data_valid_i (data_valid_i),
        .data_i       (data_i),
        .mod_i        (mod_i),
        .busy_i       (busy),
        .ready_o      (ready_o),
        .grp          (grp)
    );

    // one mapper per point of the group
    generate
        for (genvar g = 0; g < ofdm_pkg::LANES; g++)
        begin : g_lane
            constellation_mapper #(.DATA_W(DATA_W), .LANE(g)) u_mapper
            (
                .lane   (grp),
                .pt_i_o (pt_i[g]),
                .pt_q_o (pt_q[g])
            );
        end
    endgenerate

    subcarrier_framer #(.DATA_W(DATA_W)) u_framer
    (
        .clk         (clk),
        .reset       (reset),
        .grp         (grp),
        .pts_i       (pt_i),
        .pts_q       (pt_q),
        .busy_o      (busy),
        .out_valid_o (out_valid_o),
        .bin_index_o (bin_index_o),
        .out_i_o     (out_i_o),
        .out_q_o     (out_q_o),
        .sym_done_o  (sym_done_o)
    );

endmodule

`default_nettype wire
